// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f sim.f -o fir_sim
	./obj_dir/fir_sim

clean:
	rm -rf obj_dir

// File: sim.f
+incdir+verification
src/fir_pkg.sv
src/fir_taps_if.sv
src/fir_coeff_regs.sv
src/fir_tap_line.sv
src/fir_sym_mac.sv
src/fir_top.sv
verification/fir_tb.sv

// File: src/fir_coeff_regs.sv
`timescale 1ns/1ns
/*
 AXI4-Lite slave with five coefficient words from offset 0x00. Strobes are ignored
 and a write replaces the whole word. Misaligned or out-of-range offsets get SLVERR.
 Coefficients should only change while no valid sample is inside the filter.
*/
module fir_coeff_regs (
	input  logic                           clk,
	input  logic                           reset,
	// Write address and data
	input  logic                           i_awvalid,
	input  logic [fir_pkg::AXI_ADDR_W-1:0] i_awaddr,
	input  logic                           i_wvalid,
	input  logic [fir_pkg::AXI_DATA_W-1:0] i_wdata,
	// Byte lanes not supported, full-word writes only
	input  logic [3:0]                     i_wstrb,
	input  logic                           i_bready,
	// Read address
	input  logic                           i_arvalid,
	input  logic [fir_pkg::AXI_ADDR_W-1:0] i_araddr,
	input  logic                           i_rready,
	output logic                           o_awready,
	output logic                           o_wready,
	output logic                           o_bvalid,
	output logic [1:0]                     o_bresp,
	output logic                           o_arready,
	output logic                           o_rvalid,
	output logic [fir_pkg::AXI_DATA_W-1:0] o_rdata,
	output logic [1:0]                     o_rresp,
	// Live coefficients to the multipliers
	output fir_pkg::coeff_array_t          o_coeffs
);

	// Word-aligned offset inside the coefficient window
	function automatic logic addr_ok(input logic [fir_pkg::AXI_ADDR_W-1:0] addr);
		logic [fir_pkg::AXI_ADDR_W-1:0] offs;
		offs = addr - fir_pkg::COEFF_BASE_ADDR;
		return (offs[1:0] == 2'b00) && (offs[fir_pkg::AXI_ADDR_W-1:2] < fir_pkg::NUM_UNIQ);
	endfunction

	// Coefficient number from byte offset
	function automatic logic [fir_pkg::AXI_ADDR_W-3:0] addr_idx(
		input logic [fir_pkg::AXI_ADDR_W-1:0] addr
	);
		logic [fir_pkg::AXI_ADDR_W-1:0] offs;
		offs = addr - fir_pkg::COEFF_BASE_ADDR;
		return offs[fir_pkg::AXI_ADDR_W-1:2];
	endfunction

	fir_pkg::coeff_array_t coeffs_q;
	fir_pkg::sample_t rd_coeff;
	logic wr_fire;
	logic rd_fire;
	logic wr_ok;
	logic rd_ok;
	logic [fir_pkg::AXI_ADDR_W-3:0] wr_idx;
	logic [fir_pkg::AXI_ADDR_W-3:0] rd_idx;

	// ************************************************************************
	// Handshakes
	// ************************************************************************
	// Address and data taken together, only with no response outstanding
	assign wr_fire = i_awvalid && i_wvalid && !o_bvalid;
	assign o_awready = wr_fire;
	assign o_wready = wr_fire;
	// One read at a time
	assign rd_fire = i_arvalid && !o_rvalid;
	assign o_arready = rd_fire;

	// Decode
	assign wr_ok = addr_ok(i_awaddr);
	assign wr_idx = addr_idx(i_awaddr);
	assign rd_ok = addr_ok(i_araddr);
	assign rd_idx = addr_idx(i_araddr);
	// Bad read offset returns zero
	assign rd_coeff = rd_ok ? coeffs_q[rd_idx] : '0;

	// Coefficient store, low DATA_W bits of the write word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			coeffs_q <= fir_pkg::COEFF_RESET;
		end else if (wr_fire && wr_ok) begin
			coeffs_q[wr_idx] <= i_wdata[fir_pkg::DATA_W-1:0];
		end
	end

	// Response valids, held until the master is ready
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				o_bvalid <= 1'b1;
			end else if (i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				o_rvalid <= 1'b1;
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

	// Response payload, loaded at acceptance only
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			o_bresp <= wr_ok ? fir_pkg::RESP_OKAY : fir_pkg::RESP_SLVERR;
		end
		if (rd_fire) begin
			// Sign-extend to the bus width
			o_rdata <= {{(fir_pkg::AXI_DATA_W - fir_pkg::DATA_W){rd_coeff[fir_pkg::DATA_W-1]}},
				rd_coeff};
			o_rresp <= rd_ok ? fir_pkg::RESP_OKAY : fir_pkg::RESP_SLVERR;
		end
	end

	assign o_coeffs = coeffs_q;

	// Stalled write response stays up with the same code
	assert property (@(posedge clk) disable iff (reset)
		o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

	// Stalled read response keeps data and code
	assert property (@(posedge clk) disable iff (reset)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

// File: src/fir_pkg.sv
/*
 Widths, latencies, types and the register map of the symmetric FIR.
 Coefficients share the sample width. All sums wrap at DATA_W bits.
*/
package fir_pkg;

	// ************************************************************************
	// Datapath sizes
	// ************************************************************************
	localparam int DATA_W = 18;
	localparam int NUM_TAPS = 10;
	// Symmetric filter, one coefficient per tap pair
	localparam int NUM_UNIQ = 5;
	// Full signed product of two samples
	localparam int PROD_W = 36;
	// Product normalization, keeps bits 34 down to 17
	localparam int SCALE_SHIFT = 17;
	// Pre-add, multiply, three tree levels, output register
	localparam int MAC_LAT = 6;

	// Register block bus widths
	localparam int AXI_ADDR_W = 5;
	localparam int AXI_DATA_W = 32;

	typedef logic signed [DATA_W-1:0] sample_t;
	// Tap 0 is the newest sample
	typedef sample_t tap_array_t [NUM_TAPS];
	typedef sample_t coeff_array_t [NUM_UNIQ];

	// Coefficients 0 to 4 after reset
	localparam coeff_array_t COEFF_RESET = '{18'sd88, 18'sd0, -18'sd97, -18'sd197, -18'sd294};

	// ************************************************************************
	// Register map and responses
	// ************************************************************************
	// Coefficient k at byte offset 4k from here
	localparam logic [AXI_ADDR_W-1:0] COEFF_BASE_ADDR = 5'h00;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/fir_sym_mac.sv
`timescale 1ns/1ns
/*
 Pre-add, multiply and adder tree of the symmetric FIR, six enabled edges deep.
 No saturation or rounding. Sums wrap at DATA_W and products are truncated.
 o_out is only meaningful while o_valid is high.
*/
module fir_sym_mac (
	input  logic                  clk,
	input  logic                  reset,
	fir_taps_if.dst               i_taps,
	input  fir_pkg::coeff_array_t i_coeffs,
	output logic                  o_valid,
	output fir_pkg::sample_t      o_out
);

	// Stage 1 pair sums
	fir_pkg::sample_t pre_q [fir_pkg::NUM_UNIQ];
	// Stage 2 scaled products
	fir_pkg::sample_t prod_q [fir_pkg::NUM_UNIQ];
	// Full products before the shift
	logic signed [fir_pkg::PROD_W-1:0] full_prod [fir_pkg::NUM_UNIQ];
	// Tree level 1 sums and the bye for product 4
	fir_pkg::sample_t l1_sum_q [2];
	fir_pkg::sample_t l1_bye_q;
	// Tree level 2
	fir_pkg::sample_t l2_sum_q;
	fir_pkg::sample_t l2_bye_q;
	// Tree level 3 and output
	fir_pkg::sample_t l3_sum_q;
	fir_pkg::sample_t out_q;
	// One bit per stage
	logic [fir_pkg::MAC_LAT-1:0] valid_sr;

	// Signed 18x18 product always fits 36 bits
	always_comb begin
		for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
			full_prod[k] = pre_q[k] * i_coeffs[k];
		end
	end

	// ************************************************************************
	// Arithmetic pipeline
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (i_taps.ena) begin
			// Stage 1 adds tap k and tap 9-k
			for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
				pre_q[k] <= i_taps.taps[k] + i_taps.taps[fir_pkg::NUM_TAPS-1-k];
			end
			// Stage 2 keeps product bits 34 down to 17
			for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
				prod_q[k] <= full_prod[k][fir_pkg::SCALE_SHIFT +: fir_pkg::DATA_W];
			end
			// Stage 3
			l1_sum_q[0] <= prod_q[0] + prod_q[1];
			l1_sum_q[1] <= prod_q[2] + prod_q[3];
			l1_bye_q <= prod_q[4];
			// Stage 4
			l2_sum_q <= l1_sum_q[0] + l1_sum_q[1];
			l2_bye_q <= l1_bye_q;
			// Stage 5
			l3_sum_q <= l2_sum_q + l2_bye_q;
			// Stage 6 output register
			out_q <= l3_sum_q;
		end
	end

	// Valid moves with the data and freezes with it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_sr <= '0;
		end else if (i_taps.ena) begin
			valid_sr <= {valid_sr[fir_pkg::MAC_LAT-2:0], i_taps.valid};
		end
	end

	assign o_valid = valid_sr[fir_pkg::MAC_LAT-1];
	assign o_out = out_q;

	// Valid always known once out of reset
	assert property (@(posedge clk) disable iff (reset) !$isunknown(o_valid));

endmodule

// File: src/fir_tap_line.sv
`timescale 1ns/1ns
/*
 Input delay line. Shifts on every enabled edge whether or not i_valid is high,
 so invalid samples still occupy taps.
*/
module fir_tap_line (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  fir_pkg::sample_t i_in,
	fir_taps_if.src          o_taps
);

	fir_pkg::tap_array_t taps_q;
	logic valid_q;

	// ************************************************************************
	// Delay line
	// ************************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			taps_q <= '{default: '0};
			valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			// Newest into tap 0, the rest age by one
			taps_q[0] <= i_in;
			for (int k = 1; k < fir_pkg::NUM_TAPS; k++) begin
				taps_q[k] <= taps_q[k-1];
			end
			// Valid flag belongs to tap 0
			valid_q <= i_valid;
		end
	end

	// Window out
	assign o_taps.taps = taps_q;
	assign o_taps.valid = valid_q;
	// Enable forwarded for the arithmetic stages
	assign o_taps.ena = i_clk_ena;

endmodule

// File: src/fir_taps_if.sv
`timescale 1ns/1ns
/*
 Tap window from the delay line to the arithmetic.
 The enable travels with the window, so only the delay line sees the port.
*/
interface fir_taps_if;

	// Ten newest samples, tap 0 newest
	fir_pkg::tap_array_t taps;
	// Sample in tap 0 was presented with i_valid
	logic valid;
	// Pipeline advance, same cycle as the top-level clock enable
	logic ena;

	// Delay line side
	modport src (
		output taps,
		output valid,
		output ena
	);

	// Arithmetic side
	modport dst (
		input taps,
		input valid,
		input ena
	);

endinterface

// File: src/fir_top.sv
`timescale 1ns/1ns
/*
 Symmetric 10-tap FIR with AXI4-Lite coefficient registers. Output valid follows
 the sample 7 enabled edges later. No back-pressure, o_valid must be taken when high.
*/
module fir_top (
	input  logic                           clk,
	input  logic                           reset,
	// Sample stream
	input  logic                           i_clk_ena,
	input  logic                           i_valid,
	input  fir_pkg::sample_t               i_in,
	output logic                           o_valid,
	output fir_pkg::sample_t               o_out,
	// Coefficient register bus
	input  logic                           i_awvalid,
	input  logic [fir_pkg::AXI_ADDR_W-1:0] i_awaddr,
	input  logic                           i_wvalid,
	input  logic [fir_pkg::AXI_DATA_W-1:0] i_wdata,
	input  logic [3:0]                     i_wstrb,
	input  logic                           i_bready,
	input  logic                           i_arvalid,
	input  logic [fir_pkg::AXI_ADDR_W-1:0] i_araddr,
	input  logic                           i_rready,
	output logic                           o_awready,
	output logic                           o_wready,
	output logic                           o_bvalid,
	output logic [1:0]                     o_bresp,
	output logic                           o_arready,
	output logic                           o_rvalid,
	output logic [fir_pkg::AXI_DATA_W-1:0] o_rdata,
	output logic [1:0]                     o_rresp
);

	fir_pkg::coeff_array_t coeffs;

	// Tap window between delay line and arithmetic
	fir_taps_if taps_if ();

	// ************************************************************************
	// Register block
	// ************************************************************************
	fir_coeff_regs coeff_regs_i (
		.clk       (clk),
		.reset     (reset),
		.i_awvalid (i_awvalid),
		.i_awaddr  (i_awaddr),
		.i_wvalid  (i_wvalid),
		.i_wdata   (i_wdata),
		.i_wstrb   (i_wstrb),
		.i_bready  (i_bready),
		.i_arvalid (i_arvalid),
		.i_araddr  (i_araddr),
		.i_rready  (i_rready),
		.o_awready (o_awready),
		.o_wready  (o_wready),
		.o_bvalid  (o_bvalid),
		.o_bresp   (o_bresp),
		.o_arready (o_arready),
		.o_rvalid  (o_rvalid),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.o_coeffs  (coeffs)
	);

	// ************************************************************************
	// Datapath
	// ************************************************************************
	// One enabled edge into the window
	fir_tap_line tap_line_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_taps    (taps_if)
	);

	// Six more to the output
	fir_sym_mac sym_mac_i (
		.clk      (clk),
		.reset    (reset),
		.i_taps   (taps_if),
		.i_coeffs (coeffs),
		.o_valid  (o_valid),
		.o_out    (o_out)
	);

endmodule

// File: verification/fir_tb_model.svh
/*
 Reference model of the symmetric FIR, included inside the testbench module.
 Holds only while coefficients change with no valid sample in flight.
*/
`ifndef FIR_TB_MODEL_SVH
`define FIR_TB_MODEL_SVH

// Tap history, index 0 newest
fir_pkg::sample_t hist [fir_pkg::NUM_TAPS];
// Coefficients as last written over the bus
fir_pkg::sample_t coeff_mirror [fir_pkg::NUM_UNIQ];
// One {valid, value} pair per enabled edge, front is the next output
logic [fir_pkg::DATA_W:0] exp_q [$];
// Output expected after the latest enabled edge
logic exp_valid;
fir_pkg::sample_t exp_out;

// Filter response over the current history
function automatic fir_pkg::sample_t filter_value();
	longint acc;
	longint prod;
	fir_pkg::sample_t pre;
	acc = 0;
	for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
		// Pair sum wraps at 18 bits
		pre = hist[k] + hist[fir_pkg::NUM_TAPS-1-k];
		prod = longint'(pre) * longint'(coeff_mirror[k]);
		// Dropping the low 17 bits, high bits vanish in the final wrap
		acc = acc + (prod >>> fir_pkg::SCALE_SHIFT);
	end
	return fir_pkg::sample_t'(acc);
endfunction

task automatic reset_model();
	hist = '{default: '0};
	coeff_mirror = fir_pkg::COEFF_RESET;
	exp_q.delete();
	// Empty pipeline stages ahead of the first sample
	for (int k = 0; k < fir_pkg::MAC_LAT; k++) begin
		exp_q.push_back('0);
	end
	exp_valid = 1'b0;
	exp_out = '0;
endtask

// One enabled edge: shift, compute, retire the oldest pair
task automatic advance_model(input logic valid, input fir_pkg::sample_t sample);
	for (int k = fir_pkg::NUM_TAPS - 1; k > 0; k--) begin
		hist[k] = hist[k-1];
	end
	hist[0] = sample;
	exp_q.push_back({valid, filter_value()});
	{exp_valid, exp_out} = exp_q.pop_front();
endtask

// Only the low sample bits of a write are kept
task automatic mirror_coeff_write(input int idx, input logic [31:0] data);
	coeff_mirror[idx] = data[fir_pkg::DATA_W-1:0];
endtask

`endif

// File: verification/fir_tb.sv
`timescale 1ns/1ns
/*
 Testbench for fir_top with seeded random stimulus and an included model.
 Bus accesses run with the clock enable low, so the stream stays frozen.
*/
module fir_tb;

	localparam int CLK_NS = 4;
	localparam int IMPULSE_CYCLES = 20;
	localparam int RAND_CYCLES = 400;
	localparam int RAND2_CYCLES = 200;
	localparam int IDLE_CYCLES = 8;
	localparam int AXI_OPS = 40;
	// Longest single bus transfer including its stall
	localparam int AXI_OP_CYCLES = 16;
	localparam int STREAM_CYCLES = 2 + IMPULSE_CYCLES + RAND_CYCLES + RAND2_CYCLES
		+ 2 * IDLE_CYCLES;
	localparam int WATCHDOG_NS = (STREAM_CYCLES + AXI_OPS * AXI_OP_CYCLES) * CLK_NS * 2;

	logic clk;
	logic reset;
	logic clk_ena;
	logic in_valid;
	fir_pkg::sample_t in_data;
	logic out_valid;
	fir_pkg::sample_t out_data;
	logic awvalid;
	logic [fir_pkg::AXI_ADDR_W-1:0] awaddr;
	logic wvalid;
	logic [fir_pkg::AXI_DATA_W-1:0] wdata;
	logic [3:0] wstrb;
	logic bready;
	logic arvalid;
	logic [fir_pkg::AXI_ADDR_W-1:0] araddr;
	logic rready;
	logic awready;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic arready;
	logic rvalid;
	logic [fir_pkg::AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;

	`include "fir_tb_model.svh"

	fir_top fir_top_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (clk_ena),
		.i_valid   (in_valid),
		.i_in      (in_data),
		.o_valid   (out_valid),
		.o_out     (out_data),
		.i_awvalid (awvalid),
		.i_awaddr  (awaddr),
		.i_wvalid  (wvalid),
		.i_wdata   (wdata),
		.i_wstrb   (wstrb),
		.i_bready  (bready),
		.i_arvalid (arvalid),
		.i_araddr  (araddr),
		.i_rready  (rready),
		.o_awready (awready),
		.o_wready  (wready),
		.o_bvalid  (bvalid),
		.o_bresp   (bresp),
		.o_arready (arready),
		.o_rvalid  (rvalid),
		.o_rdata   (rdata),
		.o_rresp   (rresp)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// Aligned offsets 0x00 to 0x10 hold coefficients
	function automatic logic addr_in_map(input logic [fir_pkg::AXI_ADDR_W-1:0] addr);
		return (addr[1:0] == 2'b00) && (addr <= 5'h10);
	endfunction

	// ************************************************************************
	// Stream
	// ************************************************************************
	// Runs from 1 ns after one edge to 1 ns after the next
	task automatic stream_step(input logic ena, input logic valid,
		input fir_pkg::sample_t sample);
		logic prev_valid;
		fir_pkg::sample_t prev_out;
		prev_valid = out_valid;
		prev_out = out_data;
		clk_ena = ena;
		in_valid = valid;
		in_data = sample;
		@(posedge clk);
		if (ena) begin
			advance_model(valid, sample);
		end
		#1;
		// Disabled edge holds both outputs including unknown data
		if (!ena) begin
			check_value("o_valid", 32'(out_valid), 32'(prev_valid));
			check_value("o_out", 32'(out_data), 32'(prev_out));
		end
		check_value("o_valid", 32'(out_valid), 32'(exp_valid));
		if (exp_valid) begin
			check_value("o_out", 32'(out_data), 32'(exp_out));
		end
	endtask

	// Enable low on about a quarter of the cycles
	task automatic random_stream(input int cycles);
		logic ena;
		logic valid;
		fir_pkg::sample_t sample;
		for (int i = 0; i < cycles; i++) begin
			ena = ($urandom_range(3, 0) != 0);
			valid = ($urandom_range(1, 0) == 1);
			sample = fir_pkg::sample_t'($urandom);
			stream_step(ena, valid, sample);
		end
	endtask

	// Flush every valid sample out of the pipeline
	task automatic drain_stream();
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			stream_step(1'b1, 1'b0, '0);
		end
	endtask

	// ************************************************************************
	// AXI4-Lite master
	// ************************************************************************
	task automatic axi_write(input logic [fir_pkg::AXI_ADDR_W-1:0] addr,
		input logic [31:0] data, input int stall);
		logic accepted;
		logic [1:0] exp_resp;
		logic [1:0] held;
		exp_resp = addr_in_map(addr) ? fir_pkg::RESP_OKAY : fir_pkg::RESP_SLVERR;
		clk_ena = 1'b0;
		in_valid = 1'b0;
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		wstrb = 4'hf;
		bready = 1'b0;
		accepted = 1'b0;
		// Ready is combinational and sampled mid-cycle
		while (!accepted) begin
			#1;
			accepted = awready && wready;
			@(posedge clk);
			#1;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		check_value("o_bvalid", 32'(bvalid), 32'd1);
		check_value("o_bresp", 32'(bresp), 32'(exp_resp));
		held = bresp;
		// Response must wait for bready
		repeat (stall) begin
			@(posedge clk);
			#1;
			check_value("o_bvalid", 32'(bvalid), 32'd1);
			check_value("o_bresp", 32'(bresp), 32'(held));
		end
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
		check_value("o_bvalid", 32'(bvalid), 32'd0);
		if (exp_resp == fir_pkg::RESP_OKAY) begin
			mirror_coeff_write(int'(addr[fir_pkg::AXI_ADDR_W-1:2]), data);
		end
	endtask

	task automatic axi_read(input logic [fir_pkg::AXI_ADDR_W-1:0] addr, input int stall,
		output logic [31:0] data, output logic [1:0] resp);
		logic accepted;
		clk_ena = 1'b0;
		in_valid = 1'b0;
		arvalid = 1'b1;
		araddr = addr;
		rready = 1'b0;
		accepted = 1'b0;
		while (!accepted) begin
			#1;
			accepted = arready;
			@(posedge clk);
			#1;
		end
		arvalid = 1'b0;
		check_value("o_rvalid", 32'(rvalid), 32'd1);
		data = rdata;
		resp = rresp;
		// Data and code frozen while stalled
		repeat (stall) begin
			@(posedge clk);
			#1;
			check_value("o_rvalid", 32'(rvalid), 32'd1);
			check_value("o_rdata", rdata, data);
			check_value("o_rresp", 32'(rresp), 32'(resp));
		end
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
		check_value("o_rvalid", 32'(rvalid), 32'd0);
	endtask

	// Sign-extended readback of the mirror with optional random stalls
	task automatic read_all_coeffs(input int stall_max);
		logic [31:0] data;
		logic [1:0] resp;
		int stall;
		for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
			stall = (stall_max > 0) ? int'($urandom_range(stall_max, 1)) : 0;
			axi_read(5'(4 * k), stall, data, resp);
			check_value("o_rdata", data, 32'(coeff_mirror[k]));
			check_value("o_rresp", 32'(resp), 32'(fir_pkg::RESP_OKAY));
		end
	endtask

	// ************************************************************************
	// Test sequence
	// ************************************************************************
	initial begin : main_seq
		int lat;
		logic [31:0] data;
		logic [1:0] resp;
		void'($urandom(91));
		clk = 1'b0;
		reset = 1'b1;
		clk_ena = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		reset_model();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle state after reset
		check_value("o_valid", 32'(out_valid), 32'd0);
		check_value("o_bvalid", 32'(bvalid), 32'd0);
		check_value("o_rvalid", 32'(rvalid), 32'd0);
		check_value("o_awready", 32'(awready), 32'd0);
		check_value("o_wready", 32'(wready), 32'd0);
		check_value("o_arready", 32'(arready), 32'd0);
		read_all_coeffs(0);

		// Impulse with the first valid output counted in edges
		lat = 0;
		for (int i = 1; i <= IMPULSE_CYCLES; i++) begin
			if (i == 1) begin
				stream_step(1'b1, 1'b1, 18'sd1000);
			end else begin
				stream_step(1'b1, 1'b0, '0);
			end
			if (out_valid && lat == 0) begin
				lat = i;
			end
		end
		check_value("impulse latency", 32'(lat), 32'd7);

		random_stream(RAND_CYCLES);

		// New coefficients with nothing valid inside
		drain_stream();
		for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
			axi_write(5'(4 * k), $urandom, 0);
		end
		read_all_coeffs(0);
		random_stream(RAND2_CYCLES);
		drain_stream();

		// Unmapped write and misaligned read
		axi_write(5'h14, $urandom, 0);
		axi_read(5'h02, 0, data, resp);
		check_value("o_rdata", data, 32'd0);
		check_value("o_rresp", 32'(resp), 32'(fir_pkg::RESP_SLVERR));
		read_all_coeffs(0);

		// Stalled responses
		for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
			axi_write(5'(4 * k), $urandom, int'($urandom_range(8, 1)));
		end
		read_all_coeffs(8);

		$display("TEST OK");
		$finish;
	end

	// Hang guard at twice the expected run length
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the simulation hung", WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1, "Simulation timeout");
	end

endmodule
